// ==== Makefile ====
# Verilator build and run for the multiply/divide unit testbench

TOP := tb_md_unit

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^Simulation passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== md_div_core.sv ====
/*
 * Iterative restoring divider, signed and unsigned
 * Returns quotient or remainder, with a shortcut for a zero divisor
 */

`timescale 1ns/1ps

module md_div_core (
  input  logic           clk_i,
  input  logic           rst_ni,

  input  logic           start_i,
  input  md_pkg::md_op_e op_i,
  input  md_pkg::word_t  a_i,
  input  md_pkg::word_t  b_i,

  output logic           done_o,
  output md_pkg::word_t  result_o
);

  md_pkg::div_state_e state_q;
  md_pkg::div_state_e state_d;
  md_pkg::count_t     count_q;

  md_pkg::word_t numer_q;
  md_pkg::word_t denom_q;
  md_pkg::word_t rem_q;
  md_pkg::word_t quot_q;
  md_pkg::word_t result_q;
  md_pkg::word_t sign_src;

  logic is_div;
  logic is_signed;
  logic sign_a;
  logic sign_b;
  logic negate;
  logic div_by_zero;
  logic ge;

  logic [md_pkg::WordWidth:0]   sub_a;
  logic [md_pkg::WordWidth:0]   sub_b;
  logic [md_pkg::WordWidth+1:0] diff;

  ////////////////////////////////////////////////////////////
  // Operation decode
  ////////////////////////////////////////////////////////////

  assign is_div    = (op_i == md_pkg::OP_DIV) || (op_i == md_pkg::OP_DIVU);
  assign is_signed = (op_i == md_pkg::OP_DIV) || (op_i == md_pkg::OP_REM);

  assign sign_a      = a_i[md_pkg::WordWidth-1] & is_signed;
  assign sign_b      = b_i[md_pkg::WordWidth-1] & is_signed;
  assign div_by_zero = (b_i == '0);

  // Quotient takes the xor of signs, remainder follows the dividend
  assign negate   = is_div ? (sign_a ^ sign_b) : sign_a;
  assign sign_src = is_div ? quot_q : rem_q;

  ////////////////////////////////////////////////////////////
  // Subtractor
  ////////////////////////////////////////////////////////////

  // Negation in ABS and SIGN, trial subtract in COMP
  always_comb begin
    sub_a = '0;
    sub_b = {1'b0, a_i};
    unique case (state_q)
      md_pkg::DIV_ABS_B: begin
        sub_b = {1'b0, b_i};
      end
      md_pkg::DIV_COMP: begin
        sub_a = {rem_q, numer_q[md_pkg::WordWidth-1]};
        sub_b = {1'b0, denom_q};
      end
      md_pkg::DIV_SIGN: begin
        sub_b = {1'b0, sign_src};
      end
      default: begin
      end
    endcase
  end

  assign diff = {1'b0, sub_a} - {1'b0, sub_b};

  // No borrow means the shifted remainder covers the divisor
  assign ge = ~diff[md_pkg::WordWidth+1];

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      md_pkg::DIV_IDLE: begin
        if (start_i) begin
          state_d = div_by_zero ? md_pkg::DIV_DONE : md_pkg::DIV_ABS_A;
        end
      end
      md_pkg::DIV_ABS_A: state_d = md_pkg::DIV_ABS_B;
      md_pkg::DIV_ABS_B: state_d = md_pkg::DIV_COMP;
      md_pkg::DIV_COMP: begin
        if (count_q == '0) begin
          state_d = md_pkg::DIV_SIGN;
        end
      end
      md_pkg::DIV_SIGN: state_d = md_pkg::DIV_DONE;
      default:          state_d = md_pkg::DIV_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= md_pkg::DIV_IDLE;
      count_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == md_pkg::DIV_ABS_B) begin
        count_q <= md_pkg::count_t'(md_pkg::DivSteps - 1);
      end else if (state_q == md_pkg::DIV_COMP) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    unique case (state_q)
      md_pkg::DIV_IDLE: begin
        // Zero divisor: all ones quotient, remainder is the dividend
        if (start_i && div_by_zero) begin
          result_q <= is_div ? '1 : a_i;
        end
      end
      md_pkg::DIV_ABS_A: begin
        numer_q <= sign_a ? diff[md_pkg::WordWidth-1:0] : a_i;
        rem_q   <= '0;
        quot_q  <= '0;
      end
      md_pkg::DIV_ABS_B: begin
        denom_q <= sign_b ? diff[md_pkg::WordWidth-1:0] : b_i;
      end
      md_pkg::DIV_COMP: begin
        rem_q   <= ge ? diff[md_pkg::WordWidth-1:0] : sub_a[md_pkg::WordWidth-1:0];
        quot_q  <= {quot_q[md_pkg::WordWidth-2:0], ge};
        numer_q <= {numer_q[md_pkg::WordWidth-2:0], 1'b0};
      end
      md_pkg::DIV_SIGN: begin
        result_q <= negate ? diff[md_pkg::WordWidth-1:0] : sign_src;
      end
      default: begin
      end
    endcase
  end

  assign done_o   = (state_q == md_pkg::DIV_DONE);
  assign result_o = result_q;

endmodule

// ==== md_pkg.sv ====
/*
 * Multiply/divide unit shared definitions
 * Widths, operation codes, divider FSM states and SIMD saturation constants
 */

package md_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  localparam int unsigned WordWidth = 32;

  // One quotient bit per compare step
  localparam int unsigned DivSteps = 32;

  // SIMD lane counts inside one word
  localparam int unsigned HalfLanes = 2;
  localparam int unsigned ByteLanes = 4;

  typedef logic [WordWidth-1:0] word_t;
  typedef logic [15:0]          half_t;
  typedef logic [7:0]           byte_t;
  typedef logic [4:0]           count_t;

  ////////////////////////////////////////////////////////////
  // Operations and divider states
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    OP_DIV   = 3'd0,
    OP_DIVU  = 3'd1,
    OP_REM   = 3'd2,
    OP_REMU  = 3'd3,
    OP_KHM16 = 3'd4,
    OP_KHM8  = 3'd5
  } md_op_e;

  typedef enum logic [2:0] {
    DIV_IDLE,
    DIV_ABS_A,
    DIV_ABS_B,
    DIV_COMP,
    DIV_SIGN,
    DIV_DONE
  } div_state_e;

  ////////////////////////////////////////////////////////////
  // Fractional saturation
  ////////////////////////////////////////////////////////////

  // -1.0 * -1.0 is the only product that leaves the Q range
  localparam half_t Q15Max = 16'h7fff;
  localparam half_t Q15Min = 16'h8000;
  localparam byte_t Q7Max  = 8'h7f;
  localparam byte_t Q7Min  = 8'h80;

endpackage

// ==== md_req_capture.sv ====
/*
 * Request capture for the multiply/divide unit
 * Latches operation and operands and starts the selected engine
 */

`timescale 1ns/1ps

module md_req_capture (
  input  logic           clk_i,
  input  logic           rst_ni,

  input  logic           req_i,
  input  md_pkg::md_op_e op_i,
  input  md_pkg::word_t  a_i,
  input  md_pkg::word_t  b_i,
  input  logic           ack_i,

  output md_pkg::md_op_e op_o,
  output md_pkg::word_t  a_o,
  output md_pkg::word_t  b_o,
  output logic           div_start_o,
  output logic           mult_start_o
);

  logic           busy_q;
  logic           released_q;
  logic           op_is_mult;
  logic           accept;
  logic           div_start_q;
  logic           mult_start_q;
  md_pkg::md_op_e op_q;
  md_pkg::word_t  a_q;
  md_pkg::word_t  b_q;

  // SIMD multiplies go to the multiplier, everything else divides
  assign op_is_mult = (op_i == md_pkg::OP_KHM16) || (op_i == md_pkg::OP_KHM8);

  assign accept = !busy_q && req_i;

  ////////////////////////////////////////////////////////////
  // Handshake tracking
  ////////////////////////////////////////////////////////////

  // released_q remembers that req_i dropped, so a new req_i that
  // arrives right after ack_i falls is not mistaken for the old one
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q       <= 1'b0;
      released_q   <= 1'b0;
      div_start_q  <= 1'b0;
      mult_start_q <= 1'b0;
    end else begin
      div_start_q  <= accept && !op_is_mult;
      mult_start_q <= accept && op_is_mult;
      if (accept) begin
        busy_q     <= 1'b1;
        released_q <= 1'b0;
      end else if (busy_q) begin
        if ((released_q || !req_i) && !ack_i) begin
          busy_q     <= 1'b0;
          released_q <= 1'b0;
        end else if (!req_i) begin
          released_q <= 1'b1;
        end
      end
    end
  end

  // Operands stay put for the whole transaction
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q <= op_i;
      a_q  <= a_i;
      b_q  <= b_i;
    end
  end

  assign op_o         = op_q;
  assign a_o          = a_q;
  assign b_o          = b_q;
  assign div_start_o  = div_start_q;
  assign mult_start_o = mult_start_q;

endmodule

// ==== md_result_stage.sv ====
/*
 * Result stage of the multiply/divide unit
 * Holds the finished result and drives the four-phase acknowledge
 */

`timescale 1ns/1ps

module md_result_stage (
  input  logic          clk_i,
  input  logic          rst_ni,

  input  logic          req_i,

  input  logic          div_done_i,
  input  md_pkg::word_t div_result_i,
  input  logic          mult_done_i,
  input  md_pkg::word_t mult_result_i,
  input  logic          mult_ov_i,

  output logic          ack_o,
  output md_pkg::word_t result_o,
  output logic          ov_o
);

  logic          ack_q;
  logic          ov_q;
  md_pkg::word_t result_q;

  // Only one engine finishes per transaction
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q    <= 1'b0;
      ov_q     <= 1'b0;
      result_q <= '0;
    end else begin
      if (div_done_i) begin
        result_q <= div_result_i;
        ov_q     <= 1'b0;
        ack_q    <= 1'b1;
      end else if (mult_done_i) begin
        result_q <= mult_result_i;
        ov_q     <= mult_ov_i;
        ack_q    <= 1'b1;
      end else if (ack_q && !req_i) begin
        // Requester has let go, close the handshake
        ack_q <= 1'b0;
      end
    end
  end

  assign ack_o    = ack_q;
  assign result_o = result_q;
  assign ov_o     = ov_q;

endmodule

// ==== md_simd_mult.sv ====
/*
 * Saturating fractional SIMD multiplier
 * Q15 halfword lanes or Q7 byte lanes, result registered one cycle
 */

`timescale 1ns/1ps

module md_simd_mult (
  input  logic           clk_i,
  input  logic           rst_ni,

  input  logic           start_i,
  input  md_pkg::md_op_e op_i,
  input  md_pkg::word_t  a_i,
  input  md_pkg::word_t  b_i,

  output logic           done_o,
  output md_pkg::word_t  result_o,
  output logic           ov_o
);

  md_pkg::word_t                 q15_word;
  md_pkg::word_t                 q7_word;
  logic [md_pkg::HalfLanes-1:0]  q15_sat;
  logic [md_pkg::ByteLanes-1:0]  q7_sat;
  logic                          sel_q7;
  logic                          done_q;
  logic                          ov_q;
  md_pkg::word_t                 result_q;

  ////////////////////////////////////////////////////////////
  // Lane products
  ////////////////////////////////////////////////////////////

  // Q15 lanes keep product bits 30:15
  for (genvar i = 0; i < md_pkg::HalfLanes; i++) begin : g_q15
    md_pkg::half_t      op_a;
    md_pkg::half_t      op_b;
    logic signed [31:0] prod;

    assign op_a       = a_i[i*$bits(md_pkg::half_t) +: $bits(md_pkg::half_t)];
    assign op_b       = b_i[i*$bits(md_pkg::half_t) +: $bits(md_pkg::half_t)];
    assign prod       = $signed(op_a) * $signed(op_b);
    assign q15_sat[i] = (op_a == md_pkg::Q15Min) && (op_b == md_pkg::Q15Min);
    assign q15_word[i*$bits(md_pkg::half_t) +: $bits(md_pkg::half_t)] =
        q15_sat[i] ? md_pkg::Q15Max : prod[30:15];
  end

  // Q7 lanes keep product bits 14:7
  for (genvar i = 0; i < md_pkg::ByteLanes; i++) begin : g_q7
    md_pkg::byte_t      op_a;
    md_pkg::byte_t      op_b;
    logic signed [15:0] prod;

    assign op_a      = a_i[i*$bits(md_pkg::byte_t) +: $bits(md_pkg::byte_t)];
    assign op_b      = b_i[i*$bits(md_pkg::byte_t) +: $bits(md_pkg::byte_t)];
    assign prod      = $signed(op_a) * $signed(op_b);
    assign q7_sat[i] = (op_a == md_pkg::Q7Min) && (op_b == md_pkg::Q7Min);
    assign q7_word[i*$bits(md_pkg::byte_t) +: $bits(md_pkg::byte_t)] =
        q7_sat[i] ? md_pkg::Q7Max : prod[14:7];
  end

  assign sel_q7 = (op_i == md_pkg::OP_KHM8);

  ////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q <= 1'b0;
    end else begin
      done_q <= start_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      result_q <= sel_q7 ? q7_word : q15_word;
      ov_q     <= sel_q7 ? (|q7_sat) : (|q15_sat);
    end
  end

  assign done_o   = done_q;
  assign result_o = result_q;
  assign ov_o     = ov_q;

endmodule

// ==== md_unit.sv ====
/*
 * Multiply/divide unit top level
 * Four-phase req/ack port around an iterative divider and a SIMD multiplier
 */

`timescale 1ns/1ps

module md_unit (
  input  logic           clk_i,
  input  logic           rst_ni,

  input  logic           req_i,
  input  md_pkg::md_op_e op_i,
  input  md_pkg::word_t  a_i,
  input  md_pkg::word_t  b_i,

  output logic           ack_o,
  output md_pkg::word_t  result_o,
  output logic           ov_o
);

  md_pkg::md_op_e op_q;
  md_pkg::word_t  a_q;
  md_pkg::word_t  b_q;
  logic           div_start;
  logic           mult_start;

  logic           div_done;
  md_pkg::word_t  div_result;
  logic           mult_done;
  md_pkg::word_t  mult_result;
  logic           mult_ov;

  md_req_capture u_req_capture (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .op_i         (op_i),
    .a_i          (a_i),
    .b_i          (b_i),
    .ack_i        (ack_o),
    .op_o         (op_q),
    .a_o          (a_q),
    .b_o          (b_q),
    .div_start_o  (div_start),
    .mult_start_o (mult_start)
  );

  md_div_core u_div_core (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (div_start),
    .op_i     (op_q),
    .a_i      (a_q),
    .b_i      (b_q),
    .done_o   (div_done),
    .result_o (div_result)
  );

  md_simd_mult u_simd_mult (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (mult_start),
    .op_i     (op_q),
    .a_i      (a_q),
    .b_i      (b_q),
    .done_o   (mult_done),
    .result_o (mult_result),
    .ov_o     (mult_ov)
  );

  md_result_stage u_result_stage (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .div_done_i    (div_done),
    .div_result_i  (div_result),
    .mult_done_i   (mult_done),
    .mult_result_i (mult_result),
    .mult_ov_i     (mult_ov),
    .ack_o         (ack_o),
    .result_o      (result_o),
    .ov_o          (ov_o)
  );

endmodule

// ==== project.f ====
md_pkg.sv
md_req_capture.sv
md_div_core.sv
md_simd_mult.sv
md_result_stage.sv
md_unit.sv
tb_md_unit.sv

// ==== tb_md_unit.sv ====
/*
 * Testbench for the multiply/divide unit
 * Runs four-phase transactions and checks them against a reference model
 */

`timescale 1ns/1ps

module tb_md_unit;

  localparam int ClkPeriod    = 100;
  localparam int NumDivRand   = 200;
  localparam int NumMulRand   = 100;
  localparam int NumHandshake = 24;
  localparam int NumFixed     = 14;
  localparam int TotalTrans   = NumDivRand + NumMulRand + NumHandshake + NumFixed;

  logic           clk_i;
  logic           rst_ni;
  logic           req_i;
  md_pkg::md_op_e op_i;
  md_pkg::word_t  a_i;
  md_pkg::word_t  b_i;
  logic           ack_o;
  md_pkg::word_t  result_o;
  logic           ov_o;

  md_pkg::word_t  seed;
  int             pass_n;
  int             fail_n;
  int             pushed_n;
  int             checked_n;
  int             ack_rises;
  int             fail_mark;
  int             trans_mark;
  string          cur_test;
  logic           ack_prev;

  // Finished transactions waiting for the comparator
  md_pkg::md_op_e rec_op[$];
  md_pkg::word_t  rec_a[$];
  md_pkg::word_t  rec_b[$];
  md_pkg::word_t  rec_res[$];
  logic           rec_ov[$];

  md_unit u_md_unit (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (req_i),
    .op_i     (op_i),
    .a_i      (a_i),
    .b_i      (b_i),
    .ack_o    (ack_o),
    .result_o (result_o),
    .ov_o     (ov_o)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // Helpers and reference model
  ////////////////////////////////////////////////////////////

  function automatic md_pkg::word_t lcg_next(input md_pkg::word_t s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Returns {overflow, result}
  function automatic logic [32:0] ref_model(input md_pkg::md_op_e op,
                                            input md_pkg::word_t a,
                                            input md_pkg::word_t b);
    md_pkg::word_t      res;
    logic               ovf;
    logic signed [31:0] ha;
    logic signed [31:0] hb;
    logic signed [31:0] hp;
    logic signed [15:0] ba;
    logic signed [15:0] bb;
    logic signed [15:0] bp;
    res = '0;
    ovf = 1'b0;
    if (op == md_pkg::OP_KHM16) begin
      for (int i = 0; i < 2; i++) begin
        ha = 32'($signed(a[16*i +: 16]));
        hb = 32'($signed(b[16*i +: 16]));
        hp = (ha * hb) >>> 15;
        if (a[16*i +: 16] == 16'h8000 && b[16*i +: 16] == 16'h8000) begin
          res[16*i +: 16] = 16'h7fff;
          ovf = 1'b1;
        end else begin
          res[16*i +: 16] = hp[15:0];
        end
      end
    end else if (op == md_pkg::OP_KHM8) begin
      for (int i = 0; i < 4; i++) begin
        ba = 16'($signed(a[8*i +: 8]));
        bb = 16'($signed(b[8*i +: 8]));
        bp = (ba * bb) >>> 7;
        if (a[8*i +: 8] == 8'h80 && b[8*i +: 8] == 8'h80) begin
          res[8*i +: 8] = 8'h7f;
          ovf = 1'b1;
        end else begin
          res[8*i +: 8] = bp[7:0];
        end
      end
    end else if (b == '0) begin
      res = (op == md_pkg::OP_DIV || op == md_pkg::OP_DIVU) ? '1 : a;
    end else if (op == md_pkg::OP_DIVU) begin
      res = a / b;
    end else if (op == md_pkg::OP_REMU) begin
      res = a % b;
    end else if (a == 32'h8000_0000 && b == '1) begin
      // Signed overflow
      res = (op == md_pkg::OP_DIV) ? a : '0;
    end else if (op == md_pkg::OP_DIV) begin
      res = $signed(a) / $signed(b);
    end else begin
      res = $signed(a) % $signed(b);
    end
    return {ovf, res};
  endfunction

  task automatic step_clock();
    @(posedge clk_i);
    #1;
  endtask

  task automatic begin_test(input string name);
    cur_test   = name;
    fail_mark  = fail_n;
    trans_mark = pushed_n;
  endtask

  task automatic finish_test();
    while (checked_n < pushed_n) begin
      step_clock();
    end
    $display("test %s done: %0d transactions, %0d errors", cur_test,
             pushed_n - trans_mark, fail_n - fail_mark);
  endtask

  task automatic check_idle();
    assert (ack_o == 1'b0 && result_o == '0 && ov_o == 1'b0) pass_n += 1;
    else begin
      $display("mismatch test %s idle {ack,ov,result}: expected %h, actual %h",
               cur_test, 34'h0, {ack_o, ov_o, result_o});
      fail_n += 1;
    end
  endtask

  // One four-phase transaction with req_i held for hold extra cycles
  task automatic transact(input md_pkg::md_op_e op, input md_pkg::word_t a,
                          input md_pkg::word_t b, input int hold);
    md_pkg::word_t res;
    logic          ovs;
    assert (ack_o == 1'b0) pass_n += 1;
    else begin
      $display("ack_o was still high before a request in test %s", cur_test);
      fail_n += 1;
    end
    req_i = 1'b1;
    op_i  = op;
    a_i   = a;
    b_i   = b;
    step_clock();
    while (!ack_o) begin
      step_clock();
    end
    res = result_o;
    ovs = ov_o;
    for (int i = 0; i < hold; i++) begin
      step_clock();
      assert (ack_o && result_o == res && ov_o == ovs) pass_n += 1;
      else begin
        $display("mismatch test %s held {ack,ov,result}: expected %h, actual %h",
                 cur_test, {1'b1, ovs, res}, {ack_o, ov_o, result_o});
        fail_n += 1;
      end
    end
    req_i = 1'b0;
    step_clock();
    while (ack_o) begin
      step_clock();
    end
    rec_op.push_back(op);
    rec_a.push_back(a);
    rec_b.push_back(b);
    rec_res.push_back(res);
    rec_ov.push_back(ovs);
    pushed_n += 1;
  endtask

  ////////////////////////////////////////////////////////////
  // Comparator and monitors
  ////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin : compare_proc
    logic [32:0]   exp_v;
    md_pkg::word_t exp_res;
    logic          exp_ov;
    while (rec_op.size() > 0) begin
      exp_v   = ref_model(rec_op[0], rec_a[0], rec_b[0]);
      exp_res = exp_v[31:0];
      exp_ov  = exp_v[32];
      assert (rec_res[0] == exp_res) pass_n += 1;
      else begin
        $display("mismatch test %s (%s a=%h b=%h) result: expected %h, actual %h",
                 cur_test, rec_op[0].name(), rec_a[0], rec_b[0], exp_res, rec_res[0]);
        fail_n += 1;
      end
      assert (rec_ov[0] == exp_ov) pass_n += 1;
      else begin
        $display("mismatch test %s (%s a=%h b=%h) ov: expected %b, actual %b",
                 cur_test, rec_op[0].name(), rec_a[0], rec_b[0], exp_ov, rec_ov[0]);
        fail_n += 1;
      end
      void'(rec_op.pop_front());
      void'(rec_a.pop_front());
      void'(rec_b.pop_front());
      void'(rec_res.pop_front());
      void'(rec_ov.pop_front());
      checked_n += 1;
    end
  end

  // Every transaction should raise ack_o exactly once
  always @(negedge clk_i) begin
    if (ack_o && !ack_prev) begin
      ack_rises += 1;
    end
    ack_prev = ack_o;
  end

  initial begin
    #(TotalTrans * 50 * ClkPeriod);
    $display("Handshake timed out, ack_o did not respond within the time limit");
    $display("Simulation failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    md_pkg::word_t a;
    md_pkg::word_t b;
    logic [2:0]    op_sel;
    int            hold;
    clk_i     = 1'b0;
    rst_ni    = 1'b0;
    req_i     = 1'b0;
    op_i      = md_pkg::OP_DIV;
    a_i       = '0;
    b_i       = '0;
    seed      = 32'hfd3;
    pass_n    = 0;
    fail_n    = 0;
    pushed_n  = 0;
    checked_n = 0;
    ack_rises = 0;
    ack_prev  = 1'b0;

    begin_test("reset_idle");
    for (int i = 0; i < 4; i++) begin
      step_clock();
      check_idle();
    end
    rst_ni = 1'b1;
    for (int i = 0; i < 3; i++) begin
      step_clock();
      check_idle();
    end
    finish_test();

    begin_test("div_random");
    for (int i = 0; i < NumDivRand; i++) begin
      seed = lcg_next(seed);
      a    = seed;
      seed = lcg_next(seed);
      b    = seed;
      seed = lcg_next(seed);
      // Spread divisor magnitudes and keep the sign
      b    = $signed(b) >>> seed[31:27];
      transact(md_pkg::md_op_e'(3'(i % 4)), a, b, 0);
    end
    finish_test();

    begin_test("div_by_zero");
    transact(md_pkg::OP_DIV, 32'h1234_5678, '0, 0);
    transact(md_pkg::OP_DIVU, 32'hf000_0001, '0, 0);
    transact(md_pkg::OP_REM, 32'h8765_4321, '0, 0);
    transact(md_pkg::OP_REMU, 32'hdead_beef, '0, 0);
    finish_test();

    begin_test("div_overflow");
    transact(md_pkg::OP_DIV, 32'h8000_0000, 32'hffff_ffff, 0);
    transact(md_pkg::OP_REM, 32'h8000_0000, 32'hffff_ffff, 0);
    finish_test();

    begin_test("khm_random");
    for (int i = 0; i < NumMulRand; i++) begin
      seed = lcg_next(seed);
      a    = seed;
      seed = lcg_next(seed);
      b    = seed;
      transact((i % 2 == 0) ? md_pkg::OP_KHM16 : md_pkg::OP_KHM8, a, b, 0);
    end
    finish_test();

    begin_test("saturation");
    transact(md_pkg::OP_KHM16, 32'h8000_8000, 32'h8000_8000, 0);
    transact(md_pkg::OP_KHM16, 32'h8000_1234, 32'h8000_4000, 0);
    transact(md_pkg::OP_KHM16, 32'hc000_8000, 32'h8000_8000, 0);
    transact(md_pkg::OP_KHM16, 32'h7fff_8000, 32'h7fff_8000, 0);
    transact(md_pkg::OP_KHM8, 32'h8080_8080, 32'h8080_8080, 0);
    transact(md_pkg::OP_KHM8, 32'h8010_80f0, 32'h8020_7f80, 0);
    transact(md_pkg::OP_KHM8, 32'h7f80_c040, 32'h7f80_8080, 0);
    transact(md_pkg::OP_KHM8, 32'h0102_0380, 32'h8080_8080, 0);
    finish_test();

    // Back to back with a random hold on req_i
    begin_test("handshake");
    for (int i = 0; i < NumHandshake; i++) begin
      seed   = lcg_next(seed);
      a      = seed;
      seed   = lcg_next(seed);
      b      = seed;
      op_sel = seed[26:24] % 3'd6;
      hold   = int'(seed[31:29]) % 6;
      transact(md_pkg::md_op_e'(op_sel), a, b, hold);
    end
    finish_test();

    assert (ack_rises == pushed_n) pass_n += 1;
    else begin
      $display("mismatch test %s ack_o rises: expected %0d, actual %0d",
               cur_test, pushed_n, ack_rises);
      fail_n += 1;
    end

    $display("checks passed: %0d, checks failed: %0d", pass_n, fail_n);
    if (fail_n == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
